// File: filelist.f
touch_pkg.sv
touch_sclk_gen.sv
touch_cmd_decode.sv
touch_spi_engine.sv
touch_result.sv
touchpad_controller.sv
tb_clock_gen.sv
touch_adc_model.sv
tb_touchpad_controller.sv

// File: tb_touchpad_controller.sv
`timescale 1ns/10ps

module tb_touchpad_controller;

	import touch_pkg::*;

	localparam int CLK_DIV      = 4;
	localparam int REPEATS      = 3;
	localparam int FRAME_CYCLES = FRAME_LEN * 2 * CLK_DIV;
	localparam int ROUND_CYCLES = 3 * REPEATS * FRAME_CYCLES;
	// Eight full X, Y, Z rotations plus margin
	localparam int CYCLE_LIMIT  = 8 * ROUND_CYCLES + 5600;

	logic          cclk;
	logic          counter_rst;
	logic          data_in;
	logic          touch_clk;
	logic          data_out;
	logic          touch_csb;
	touch_sample_t x;
	touch_sample_t y;
	touch_sample_t z;
	logic          coord_update;
	touch_sample_t val_x;
	touch_sample_t val_y;
	touch_sample_t val_z;
	touch_cmd_t    cmd_byte;
	int            cmd_count;
	touch_cmd_t    cmd_log[$];
	touch_sample_t exp_x;
	touch_sample_t exp_y;
	touch_sample_t exp_z;
	touch_axis_e   next_axis;
	int            seed;
	int            cycles = 0;
	int            checks = 0;
	int            errors = 0;
	int            tests  = 0;

	tb_clock_gen u_clock_gen (
		.cclk        (cclk),
		.counter_rst (counter_rst)
	);

	touchpad_controller #(
		.CLK_DIV (CLK_DIV),
		.REPEATS (REPEATS)
	) u_dut (
		.cclk         (cclk),
		.counter_rst  (counter_rst),
		.data_in      (data_in),
		.touch_clk    (touch_clk),
		.data_out     (data_out),
		.touch_csb    (touch_csb),
		.x            (x),
		.y            (y),
		.z            (z),
		.coord_update (coord_update)
	);

	touch_adc_model u_adc (
		.touch_clk (touch_clk),
		.touch_csb (touch_csb),
		.data_out  (data_out),
		.x_val     (val_x),
		.y_val     (val_y),
		.z_val     (val_z),
		.data_in   (data_in),
		.cmd_byte  (cmd_byte),
		.cmd_count (cmd_count)
	);

	// Byte is read once both model outputs have settled
	always @(cmd_count) begin
		if (cmd_count > 0) begin
			#1;
			cmd_log.push_back(cmd_byte);
		end
	end

	always @(posedge cclk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cclk cycles, coordinate updates stopped", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// Offset removal, floor at zero, cap at the post-adjust maximum
	function automatic touch_sample_t expect_adjusted(input int raw, input int min_val,
			input int max_val);
		int diff;
		diff = raw - min_val;
		if (diff < 0) begin
			diff = 0;
		end
		if (diff > max_val) begin
			diff = max_val;
		end
		return touch_sample_t'(diff);
	endfunction

	task automatic check_value(input string name, input logic [11:0] expected,
			input logic [11:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests++;
		$display("[%0t ns] %s done, %0d errors", $time, name, errors - err_start);
	endtask

	task automatic wait_update();
		do begin
			@(posedge cclk);
			#1;
		end while (coord_update !== 1'b1);
	endtask

	// All three outputs, so a change on the wrong axis shows up too
	task automatic compare_outputs();
		case (next_axis)
			AXIS_X:  exp_x = expect_adjusted(val_x, X_ADJ_MIN, X_POST_ADJ_MAX);
			AXIS_Y:  exp_y = expect_adjusted(val_y, Y_ADJ_MIN, Y_POST_ADJ_MAX);
			default: exp_z = val_z;
		endcase
		check_value("x", exp_x, x);
		check_value("y", exp_y, y);
		check_value("z", exp_z, z);
		case (next_axis)
			AXIS_X:  next_axis = AXIS_Y;
			AXIS_Y:  next_axis = AXIS_Z;
			default: next_axis = AXIS_X;
		endcase
	endtask

	// Values change right after an update, before the next channel's command ends
	task automatic run_rotation(input touch_sample_t vx, input touch_sample_t vy,
			input touch_sample_t vz);
		val_x = vx;
		val_y = vy;
		val_z = vz;
		repeat (3) begin
			wait_update();
			compare_outputs();
		end
	endtask

	task automatic test_reset();
		int err_start;
		err_start = errors;
		@(posedge cclk);
		#1;
		check_value("touch_csb", 1'b1, touch_csb);
		check_value("touch_clk", 1'b0, touch_clk);
		check_value("data_out", 1'b0, data_out);
		check_value("coord_update", 1'b0, coord_update);
		check_value("x", '0, x);
		check_value("y", '0, y);
		check_value("z", '0, z);
		wait (counter_rst == 1'b0);
		// Chip select stays low through the scan up to the first update
		do begin
			@(posedge cclk);
			#1;
			check_value("touch_csb", 1'b0, touch_csb);
		end while (coord_update !== 1'b1);
		compare_outputs();
		finish_test("test_reset", err_start);
	endtask

	task automatic test_order();
		int err_start;
		err_start = errors;
		run_rotation(12'h200, 12'h400, 12'h9ab);
		finish_test("test_order", err_start);
	endtask

	task automatic test_commands();
		int          err_start;
		touch_axis_e axis;
		touch_cmd_t  expected;
		err_start = errors;
		checks++;
		assert (cmd_log.size() >= 3 * REPEATS) else begin
			$display("Only %0d command bytes were seen by the ADC model", cmd_log.size());
			errors++;
		end
		foreach (cmd_log[i]) begin
			case ((i / REPEATS) % 3)
				0:       axis = AXIS_X;
				1:       axis = AXIS_Y;
				default: axis = AXIS_Z;
			endcase
			// Start, channel, single-ended 12-bit conversion, power-down 11
			expected = {1'b1, axis, 5'b00111};
			check_value($sformatf("cmd[%0d]", i), expected, cmd_log[i]);
		end
		finish_test("test_commands", err_start);
	endtask

	// Full scale stays under ADJ_MIN + POST_ADJ_MAX on both axes
	task automatic test_xy_adjust();
		int err_start;
		err_start = errors;
		run_rotation(12'h050, 12'h800, 12'h111);
		run_rotation(12'h096, 12'h12b, 12'h222);
		run_rotation(12'hfff, 12'hfff, 12'h333);
		finish_test("test_xy_adjust", err_start);
	endtask

	task automatic test_z_pass();
		int err_start;
		err_start = errors;
		repeat (2) begin
			run_rotation(12'h300, 12'h300, touch_sample_t'($random(seed)));
		end
		finish_test("test_z_pass", err_start);
	endtask

	task automatic test_random();
		int            err_start;
		touch_sample_t rx;
		touch_sample_t ry;
		touch_sample_t rz;
		err_start = errors;
		repeat (2) begin
			rx = touch_sample_t'($random(seed));
			ry = touch_sample_t'($random(seed));
			rz = touch_sample_t'($random(seed));
			run_rotation(rx, ry, rz);
		end
		finish_test("test_random", err_start);
	endtask

	initial begin
		seed      = 32'hce86;
		val_x     = 12'h3a0;
		val_y     = 12'h5c4;
		val_z     = 12'h7e1;
		exp_x     = '0;
		exp_y     = '0;
		exp_z     = '0;
		next_axis = AXIS_X;
		test_reset();
		test_order();
		test_xy_adjust();
		test_z_pass();
		test_random();
		// Command log covers every frame of the run by now
		test_commands();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: touch_adc_model.sv
`timescale 1ns/10ps

module touch_adc_model (
	input  logic                     touch_clk,
	input  logic                     touch_csb,
	input  logic                     data_out,
	input  touch_pkg::touch_sample_t x_val,
	input  touch_pkg::touch_sample_t y_val,
	input  touch_pkg::touch_sample_t z_val,
	output logic                     data_in,
	output touch_pkg::touch_cmd_t    cmd_byte,
	output int                       cmd_count
);

	import touch_pkg::*;

	int            period = -1;
	touch_cmd_t    cmd_sr = '0;
	touch_sample_t conv   = '0;

	initial begin
		data_in   = 1'b0;
		cmd_byte  = '0;
		cmd_count = 0;
	end

	// Frame position moves on each falling touch_clk while selected
	always @(negedge touch_clk) begin
		if (touch_csb !== 1'b0) begin
			period = -1;
		end else if (period == FRAME_LEN - 1) begin
			period = 0;
		end else begin
			period = period + 1;
		end
		// Result goes out MSB first, one bit per falling edge
		if (period >= RESP_START && period < RESP_START + RESP_BITS) begin
			data_in <= conv[RESP_START + RESP_BITS - 1 - period];
		end else begin
			data_in <= 1'b0;
		end
	end

	// Command bits are taken on rising edges
	always @(posedge touch_clk) begin
		if (touch_csb === 1'b0 && period >= 0 && period < CMD_BITS) begin
			cmd_sr = {cmd_sr[CMD_BITS-2:0], data_out};
			if (period == CMD_BITS - 1) begin
				case (cmd_sr[6:5])
					2'b01:   conv = x_val;
					2'b00:   conv = y_val;
					2'b10:   conv = z_val;
					default: conv = '0;
				endcase
				cmd_byte  <= cmd_sr;
				cmd_count <= cmd_count + 1;
			end
		end
	end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 5
) (
	output logic cclk,
	output logic counter_rst
);

	initial begin
		cclk = 1'b0;
		forever #(HALF_PERIOD) cclk = ~cclk;
	end

	// Reset drops just after a rising edge
	initial begin
		counter_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge cclk);
		#1;
		counter_rst = 1'b0;
	end

endmodule

// File: touchpad_controller.sv
`timescale 1ns/10ps

module touchpad_controller #(
	parameter int CLK_DIV = 25,
	parameter int REPEATS = 17
) (
	input  logic                     cclk,
	input  logic                     counter_rst,
	input  logic                     data_in,
	output logic                     touch_clk,
	output logic                     data_out,
	output logic                     touch_csb,
	output touch_pkg::touch_sample_t x,
	output touch_pkg::touch_sample_t y,
	output touch_pkg::touch_sample_t z,
	output logic                     coord_update
);

	import touch_pkg::*;

	logic       sclk_rise;
	logic       sclk_fall;
	logic       frame_done;
	logic       last_rep;
	logic       rsp_valid;
	touch_req_t req;
	touch_rsp_t rsp;

	touch_sclk_gen #(
		.CLK_DIV (CLK_DIV)
	) u_sclk_gen (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.touch_clk   (touch_clk),
		.sclk_rise   (sclk_rise),
		.sclk_fall   (sclk_fall)
	);

	touch_cmd_decode #(
		.REPEATS (REPEATS)
	) u_cmd_decode (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.frame_done  (frame_done),
		.req         (req),
		.last_rep    (last_rep)
	);

	touch_spi_engine u_spi_engine (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.sclk_rise   (sclk_rise),
		.sclk_fall   (sclk_fall),
		.req         (req),
		.data_in     (data_in),
		.last_rep    (last_rep),
		.data_out    (data_out),
		.touch_csb   (touch_csb),
		.frame_done  (frame_done),
		.rsp         (rsp),
		.rsp_valid   (rsp_valid)
	);

	touch_result u_result (
		.cclk         (cclk),
		.counter_rst  (counter_rst),
		.rsp          (rsp),
		.rsp_valid    (rsp_valid),
		.x            (x),
		.y            (y),
		.z            (z),
		.coord_update (coord_update)
	);

endmodule

// File: touch_result.sv
`timescale 1ns/10ps

module touch_result (
	input  logic                     cclk,
	input  logic                     counter_rst,
	input  touch_pkg::touch_rsp_t    rsp,
	input  logic                     rsp_valid,
	output touch_pkg::touch_sample_t x,
	output touch_pkg::touch_sample_t y,
	output touch_pkg::touch_sample_t z,
	output logic                     coord_update
);

	import touch_pkg::*;

	touch_sample_t adj_x;
	touch_sample_t adj_y;
	logic          store;

	// Remove offset, floor at zero, then cap
	function automatic touch_sample_t adjust(
		input touch_sample_t raw,
		input touch_sample_t min_val,
		input touch_sample_t max_val
	);
		touch_sample_t diff;
		if (raw < min_val) begin
			return '0;
		end
		diff = raw - min_val;
		if (diff > max_val) begin
			return max_val;
		end
		return diff;
	endfunction

	assign adj_x = adjust(rsp.sample, X_ADJ_MIN, X_POST_ADJ_MAX);
	assign adj_y = adjust(rsp.sample, Y_ADJ_MIN, Y_POST_ADJ_MAX);

	// Earlier repetitions only let the front end settle
	assign store = rsp_valid && rsp.last;

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			x            <= '0;
			y            <= '0;
			z            <= '0;
			coord_update <= 1'b0;
		end else begin
			coord_update <= store;
			if (store) begin
				case (rsp.axis)
					AXIS_X:  x <= adj_x;
					AXIS_Y:  y <= adj_y;
					AXIS_Z:  z <= rsp.sample;
					default: begin
					end
				endcase
			end
		end
	end

endmodule

// File: touch_spi_engine.sv
`timescale 1ns/10ps

module touch_spi_engine (
	input  logic                  cclk,
	input  logic                  counter_rst,
	input  logic                  sclk_rise,
	input  logic                  sclk_fall,
	input  touch_pkg::touch_req_t req,
	input  logic                  data_in,
	input  logic                  last_rep,
	output logic                  data_out,
	output logic                  touch_csb,
	output logic                  frame_done,
	output touch_pkg::touch_rsp_t rsp,
	output logic                  rsp_valid
);

	import touch_pkg::*;

	frame_state_e  state;
	frame_cnt_t    bit_cnt;
	touch_cmd_t    cmd_sr;
	touch_sample_t rsp_sr;
	logic          frame_end;
	logic          last_bit;
	logic          load_cmd;
	logic          capture;

	// Period counter sits on the final tail bit
	assign last_bit = (state == TAIL) && (bit_cnt == frame_cnt_t'(FRAME_LEN - 1));

	// New frame starts on a falling edge
	assign load_cmd = sclk_fall && ((state == IDLE) || last_bit);

	// Response is complete, so report it in the second half of the last bit
	assign capture = sclk_rise && last_bit;

	assign frame_done = frame_end;
	assign rsp_valid  = frame_end;

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			state     <= IDLE;
			bit_cnt   <= '0;
			data_out  <= 1'b0;
			touch_csb <= 1'b1;
			frame_end <= 1'b0;
		end else begin
			touch_csb <= 1'b0;
			frame_end <= capture;
			if (load_cmd) begin
				state    <= CMD;
				bit_cnt  <= '0;
				data_out <= req.cmd[CMD_BITS-1];
			end else if (sclk_fall) begin
				bit_cnt <= bit_cnt + 1'b1;
				case (state)
					CMD: begin
						if (bit_cnt == frame_cnt_t'(CMD_BITS - 1)) begin
							state    <= WAIT;
							data_out <= 1'b0;
						end else begin
							data_out <= cmd_sr[CMD_BITS-2];
						end
					end
					WAIT: begin
						// Busy bit from the ADC
						if (bit_cnt == frame_cnt_t'(RESP_START - 1)) begin
							state <= RESP;
						end
					end
					RESP: begin
						if (bit_cnt == frame_cnt_t'(RESP_END)) begin
							state <= TAIL;
						end
					end
					TAIL: begin
					end
					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

	// Shift registers and response payload
	always_ff @(posedge cclk) begin
		if (load_cmd) begin
			cmd_sr <= req.cmd;
		end else if (sclk_fall && (state == CMD)) begin
			cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b0};
		end
		if (sclk_rise && (state == RESP)) begin
			rsp_sr <= {rsp_sr[RESP_BITS-2:0], data_in};
		end
		if (capture) begin
			rsp.axis   <= req.axis;
			rsp.sample <= rsp_sr;
			rsp.last   <= last_rep;
		end
	end

	a_done_in_tail: assert property (
		@(posedge cclk) disable iff (counter_rst)
		frame_done |-> (state == TAIL)
	) else $error("frame_done outside the tail of a frame");

endmodule

// File: touch_cmd_decode.sv
`timescale 1ns/10ps

module touch_cmd_decode #(
	parameter int REPEATS = 17
) (
	input  logic                 cclk,
	input  logic                 counter_rst,
	input  logic                 frame_done,
	output touch_pkg::touch_req_t req,
	output logic                 last_rep
);

	import touch_pkg::*;

	localparam int REP_W = (REPEATS > 1) ? $clog2(REPEATS) : 1;

	touch_axis_e      axis;
	logic [REP_W-1:0] rep_cnt;

	// Channel rotation X, Y, Z
	function automatic touch_axis_e next_axis(input touch_axis_e cur);
		touch_axis_e nxt;
		case (cur)
			AXIS_X:  nxt = AXIS_Y;
			AXIS_Y:  nxt = AXIS_Z;
			default: nxt = AXIS_X;
		endcase
		return nxt;
	endfunction

	assign last_rep = (rep_cnt == REP_W'(REPEATS - 1));

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			axis    <= AXIS_X;
			rep_cnt <= '0;
		end else if (frame_done) begin
			if (last_rep) begin
				rep_cnt <= '0;
				axis    <= next_axis(axis);
			end else begin
				rep_cnt <= rep_cnt + 1'b1;
			end
		end
	end

	// Only changes on frame_done, so stable across a frame
	always_comb begin
		req.axis = axis;
		req.cmd  = touch_cmd_build(axis);
	end

	a_axis_valid: assert property (
		@(posedge cclk) disable iff (counter_rst)
		axis != touch_axis_e'(2'b11)
	) else $error("channel select holds reserved code 3");

endmodule

// File: touch_sclk_gen.sv
`timescale 1ns/10ps

module touch_sclk_gen #(
	parameter int CLK_DIV = 25
) (
	input  logic cclk,
	input  logic counter_rst,
	output logic touch_clk,
	output logic sclk_rise,
	output logic sclk_fall
);

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             div_end;

	// Half period done, toggle on the next edge
	assign div_end = (div_cnt == DIV_W'(CLK_DIV - 1));

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			div_cnt   <= '0;
			touch_clk <= 1'b0;
			sclk_rise <= 1'b0;
			sclk_fall <= 1'b0;
		end else begin
			// Strobes line up with the touch_clk transition
			sclk_rise <= div_end && !touch_clk;
			sclk_fall <= div_end && touch_clk;
			if (div_end) begin
				div_cnt   <= '0;
				touch_clk <= ~touch_clk;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	a_edges_exclusive: assert property (
		@(posedge cclk) disable iff (counter_rst)
		!(sclk_rise && sclk_fall)
	) else $error("sclk_rise and sclk_fall high together");

endmodule

// File: touch_pkg.sv
package touch_pkg;

	// Raw or adjusted conversion result
	typedef logic [11:0] touch_sample_t;

	// Command byte sent at the start of a frame
	typedef logic [7:0] touch_cmd_t;

	// Channel select, also the A1..A0 field of the command byte
	typedef enum logic [1:0] {
		AXIS_Y = 2'b00,
		AXIS_X = 2'b01,
		AXIS_Z = 2'b10
	} touch_axis_e;

	// Command byte layout, MSB first on the wire
	// [7] start, [6:5] channel, [4] zero, [3] mode, [2] ser/dfr, [1:0] power-down
	localparam logic       CMD_START    = 1'b1;
	localparam logic       CMD_A2       = 1'b0;
	localparam logic       CMD_MODE_12B = 1'b0;
	localparam logic       CMD_SER      = 1'b1;
	localparam logic [1:0] CMD_PD       = 2'b11;

	// Frame layout in touch_clk periods
	localparam int CMD_BITS   = 8;
	localparam int RESP_START = 9;
	localparam int RESP_BITS  = 12;
	localparam int RESP_END   = RESP_START + RESP_BITS - 1;
	localparam int FRAME_LEN  = 25;

	typedef logic [$clog2(FRAME_LEN)-1:0] frame_cnt_t;

	typedef enum logic [2:0] {IDLE, CMD, WAIT, RESP, TAIL} frame_state_e;

	typedef struct packed {
		touch_axis_e axis;
		touch_cmd_t  cmd;
	} touch_req_t;

	typedef struct packed {
		touch_axis_e   axis;
		touch_sample_t sample;
		logic          last;
	} touch_rsp_t;

	// Coordinate trim
	localparam touch_sample_t X_ADJ_MIN      = 12'h096;
	localparam touch_sample_t X_POST_ADJ_MAX = 12'hF6E;
	localparam touch_sample_t Y_ADJ_MIN      = 12'h12C;
	localparam touch_sample_t Y_POST_ADJ_MAX = 12'hED8;

	function automatic touch_cmd_t touch_cmd_build(input touch_axis_e axis);
		touch_cmd_t cmd;
		cmd = {CMD_START, axis, CMD_A2, CMD_MODE_12B, CMD_SER, CMD_PD};
		return cmd;
	endfunction

endpackage
